//--- uart_cases.txt
# columns: mode word, byte count in decimal, then that many bytes in hex
# modes: loop, burst, badstop (first frame has a low stop bit), overrun
loop 3 a5 3c 01
loop 1 00
loop 4 80 7e ff 10
burst 6 55 aa 0f f0 c3 3c
burst 8 01 02 04 08 10 20 40 80
badstop 2 e7 5a
badstop 3 00 99 66
overrun 6 11 22 33 44 55 66
loop 2 de ad

//--- project.f
uart_cfg_pkg.sv
uart_types_pkg.sv
uart_fifo.sv
uart_tx.sv
uart_rx.sv
uart_link.sv
uart_link_checker.sv
tb_uart_link.sv

//--- Bender.yml
package:
  name: uart_link

sources:
  - uart_cfg_pkg.sv
  - uart_types_pkg.sv
  - uart_fifo.sv
  - uart_tx.sv
  - uart_rx.sv
  - uart_link.sv
  - target: test
    files:
      - uart_link_checker.sv
      - tb_uart_link.sv

//--- tb_uart_link.sv
// reads uart_cases.txt from the project root; rx_ready is random except in overrun mode
`timescale 1ns/1ps
`default_nettype none

module tb_uart_link;

    import uart_cfg_pkg::*;

    localparam int MAX_BYTES = 16;

    logic          clk;
    logic          rst_n;
    logic [7:0]    tx_data;
    logic          tx_valid;
    logic          tx_ready;
    logic          txd;
    logic          rxd;
    logic [7:0]    rx_data;
    logic          rx_valid;
    logic          rx_ready;
    logic          frame_err;
    logic          rx_overrun;

    logic          loop_sel;
    logic          line_drv;
    logic          saw_full;
    logic [7:0]    case_bytes [MAX_BYTES];
    logic [7:0]    exp_q [$];
    logic [127:0]  mode_word;
    logic [1023:0] line_buf;
    integer        seed;
    integer        fd;
    integer        code;
    int            n_bytes;
    int            fe_count;
    int            ovr_count;
    int            value_errs;
    int            other_errs;
    int            timeout_errs;
    int            assert_errs;

    uart_link uart_link_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready),
        .txd        (txd),
        .rxd        (rxd),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .rx_ready   (rx_ready),
        .frame_err  (frame_err),
        .rx_overrun (rx_overrun)
    );

    // serial line, loopback or driven frame by frame
    assign rxd = loop_sel ? txd : line_drv;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(negedge clk) begin
        if (rst_n && frame_err) fe_count++;
        if (rst_n && rx_overrun) ovr_count++;
    end

    // start bit plus the run of low data bits from the LSB
    function automatic int low_run_bits(input logic [7:0] b);
        int k;
        k = 1;
        while (k <= 8 && !b[k-1]) k++;
        return k;
    endfunction

    task automatic hold_bit(input logic level);
        line_drv = level;
        repeat (CLKS_PER_BIT) @(posedge clk);
        #1;
    endtask

    task automatic drive_frame(input logic [7:0] b, input logic stop_level);
        int i;
        hold_bit(1'b0);
        for (i = 0; i < 8; i++) hold_bit(b[i]);
        hold_bit(stop_level);
        hold_bit(1'b1);
    endtask

    task automatic send_bytes(input int n, input bit gaps);
        int i;
        int t;
        int gap;
        for (i = 0; i < n; i++) begin
            tx_data = case_bytes[i];
            tx_valid = 1'b1;
            t = 0;
            @(negedge clk);
            while (!tx_ready && t < 20 * CLKS_PER_BIT) begin
                saw_full = 1'b1;
                t++;
                @(negedge clk);
            end
            if (!tx_ready) begin
                timeout_errs++;
                $display("timed out waiting for tx_ready on byte %0d", i);
                tx_valid = 1'b0;
                return;
            end
            @(posedge clk);
            #1;
            tx_valid = 1'b0;
            gap = gaps ? ($random(seed) & 7) : 0;
            if (gap > 0) begin
                repeat (gap) @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic check_start_bit(input logic [7:0] first);
        int t;
        int low;
        int want;
        want = low_run_bits(first) * CLKS_PER_BIT;
        t = 0;
        low = 0;
        @(negedge clk);
        while (txd && t < 20 * CLKS_PER_BIT) begin
            t++;
            @(negedge clk);
        end
        if (txd) begin
            timeout_errs++;
            $display("timed out waiting for a start bit on txd");
            return;
        end
        while (!txd && low < 12 * CLKS_PER_BIT) begin
            low++;
            @(negedge clk);
        end
        if (low != want) begin
            value_errs++;
            $display("ERR txd low cycles: got %h, expected %h", low, want);
        end
    endtask

    task automatic collect_bytes(input int n, input bit random_ready);
        int got;
        int t;
        int limit;
        logic [7:0] want;
        got = 0;
        t = 0;
        limit = n * (12 * CLKS_PER_BIT + 16) + 100;
        while (got < n && t < limit) begin
            @(negedge clk);
            if (rx_valid && rx_ready) begin
                if (exp_q.size() == 0) begin
                    other_errs++;
                    $display("received a byte while none was expected");
                end else begin
                    want = exp_q.pop_front();
                    if (rx_data !== want) begin
                        value_errs++;
                        $display("ERR rx_data: got %h, expected %h", rx_data, want);
                    end
                end
                got++;
            end
            @(posedge clk);
            #1;
            if (random_ready) rx_ready = ($random(seed) % 4) != 0;
            t++;
        end
        if (got < n) begin
            timeout_errs++;
            $display("timed out waiting for received bytes, %0d of %0d arrived", got, n);
        end
    endtask

    task automatic run_case(input logic [127:0] mode, input int n);
        int i;
        int exp_fe;
        int exp_ovr;
        int exp_n;
        fe_count = 0;
        ovr_count = 0;
        exp_fe = 0;
        exp_ovr = 0;
        saw_full = 1'b0;
        exp_q.delete();
        if (mode == "loop" || mode == "burst") begin
            loop_sel = 1'b1;
            for (i = 0; i < n; i++) exp_q.push_back(case_bytes[i]);
            fork
                send_bytes(n, mode == "loop");
                check_start_bit(case_bytes[0]);
                collect_bytes(n, 1'b1);
            join
            if (mode == "burst" && !saw_full) begin
                other_errs++;
                $display("tx_ready never fell during the burst");
            end
        end else if (mode == "badstop") begin
            loop_sel = 1'b0;
            exp_fe = 1;
            for (i = 1; i < n; i++) exp_q.push_back(case_bytes[i]);
            fork
                begin
                    drive_frame(case_bytes[0], 1'b0);
                    for (i = 1; i < n; i++) drive_frame(case_bytes[i], 1'b1);
                end
                collect_bytes(n - 1, 1'b1);
            join
        end else if (mode == "overrun") begin
            loop_sel = 1'b0;
            rx_ready = 1'b0;
            exp_n = (n > FIFO_DEPTH) ? FIFO_DEPTH : n;
            exp_ovr = n - exp_n;
            for (i = 0; i < exp_n; i++) exp_q.push_back(case_bytes[i]);
            // each frame ends with an idle bit, so its strobe is already done
            for (i = 0; i < n; i++) drive_frame(case_bytes[i], 1'b1);
            rx_ready = 1'b1;
            collect_bytes(exp_n, 1'b0);
        end else begin
            other_errs++;
            $display("unknown mode word in the case file");
        end
        rx_ready = 1'b0;
        repeat (2 * CLKS_PER_BIT) @(posedge clk);
        @(negedge clk);
        if (rx_valid) begin
            other_errs++;
            $display("an extra byte was left in the receive FIFO");
        end
        if (fe_count != exp_fe) begin
            value_errs++;
            $display("ERR frame_err pulses: got %h, expected %h", fe_count, exp_fe);
        end
        if (ovr_count != exp_ovr) begin
            value_errs++;
            $display("ERR rx_overrun pulses: got %h, expected %h", ovr_count, exp_ovr);
        end
        @(posedge clk);
        #1;
        loop_sel = 1'b1;
        line_drv = 1'b1;
    endtask

    initial begin
        seed = 32'h1002;
        rst_n = 1'b0;
        tx_data = 8'h00;
        tx_valid = 1'b0;
        rx_ready = 1'b0;
        loop_sel = 1'b1;
        line_drv = 1'b1;
        saw_full = 1'b0;
        fe_count = 0;
        ovr_count = 0;
        value_errs = 0;
        other_errs = 0;
        timeout_errs = 0;
        assert_errs = 0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        if (txd !== 1'b1) begin
            value_errs++;
            $display("ERR txd: got %h, expected %h", txd, 1'b1);
        end
        if (tx_ready !== 1'b1) begin
            value_errs++;
            $display("ERR tx_ready: got %h, expected %h", tx_ready, 1'b1);
        end
        if (rx_valid !== 1'b0) begin
            value_errs++;
            $display("ERR rx_valid: got %h, expected %h", rx_valid, 1'b0);
        end
        repeat (20) @(posedge clk);
        #1;
        if (fe_count != 0 || ovr_count != 0) begin
            other_errs++;
            $display("frame_err or rx_overrun pulsed while the line was idle");
        end
        fd = $fopen("uart_cases.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("could not open the case file");
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", mode_word);
                if (code != 1) break;
                if (mode_word == "#") begin
                    code = $fgets(line_buf, fd);
                    continue;
                end
                code = $fscanf(fd, "%d", n_bytes);
                if (code != 1 || n_bytes < 1 || n_bytes > MAX_BYTES) begin
                    other_errs++;
                    $display("bad byte count in the case file");
                    break;
                end
                for (int i = 0; i < n_bytes; i++) code = $fscanf(fd, "%h", case_bytes[i]);
                run_case(mode_word, n_bytes);
            end
            $fclose(fd);
        end
        assert_errs = uart_link_inst.checker_inst.fail_count;
        $display("errors: %0d value, %0d other, %0d timeout, %0d assertion", value_errs,
                 other_errs, timeout_errs, assert_errs);
        if (value_errs + other_errs + timeout_errs + assert_errs == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- uart_link_checker.sv
// protocol assertions for uart_link, bound to every instance; inactive while rst_n is low
`timescale 1ns/1ps
`default_nettype none

module uart_link_checker (
    input logic       clk,
    input logic       rst_n,
    input logic [7:0] tx_data,
    input logic       tx_valid,
    input logic       tx_ready,
    input logic       txd,
    input logic       tx_idle,
    input logic       rx_valid,
    input logic       rx_ready,
    input logic       frame_err,
    input logic       rx_overrun
);

    // number of failed assertions so far
    int fail_count = 0;

    // user holds its byte while the transmit FIFO is full
    tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (tx_valid && !tx_ready) |=> $stable(tx_data))
        else begin
            $error("tx_data changed while waiting for tx_ready");
            fail_count++;
        end

    // line idles high
    txd_idle: assert property (@(posedge clk) disable iff (!rst_n) tx_idle |-> txd)
        else begin
            $error("txd low while the transmitter is idle");
            fail_count++;
        end

    fe_pulse: assert property (@(posedge clk) disable iff (!rst_n) frame_err |=> !frame_err)
        else begin
            $error("frame_err held for more than one cycle");
            fail_count++;
        end

    ovr_pulse: assert property (@(posedge clk) disable iff (!rst_n) rx_overrun |=> !rx_overrun)
        else begin
            $error("rx_overrun held for more than one cycle");
            fail_count++;
        end

    rx_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (rx_valid && !rx_ready) |=> rx_valid)
        else begin
            $error("rx_valid dropped without a transfer");
            fail_count++;
        end

endmodule

bind uart_link uart_link_checker checker_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .tx_data    (tx_data),
    .tx_valid   (tx_valid),
    .tx_ready   (tx_ready),
    .txd        (txd),
    .tx_idle    (txq_pop),
    .rx_valid   (rx_valid),
    .rx_ready   (rx_ready),
    .frame_err  (frame_err),
    .rx_overrun (rx_overrun)
);

`default_nettype wire

//--- uart_link.sv
// UART link top; fixed baud from uart_cfg_pkg, 8N1 only, no flow-control pins
`timescale 1ns/1ps
`default_nettype none

module uart_link (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] tx_data,
    input  logic       tx_valid,
    output logic       tx_ready,
    output logic       txd,
    input  logic       rxd,
    output logic [7:0] rx_data,
    output logic       rx_valid,
    input  logic       rx_ready,
    output logic       frame_err,
    output logic       rx_overrun
);

    logic [7:0] txq_data;
    logic       txq_valid;
    logic       txq_pop;
    logic [7:0] rx_byte;
    logic       rx_strobe;

    // transmit path, the serializer pops only when idle
    uart_fifo tx_fifo_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (tx_data),
        .in_valid  (tx_valid),
        .in_ready  (tx_ready),
        .out_data  (txq_data),
        .out_valid (txq_valid),
        .out_ready (txq_pop),
        .overrun   ()
    );

    uart_tx tx_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_data  (txq_data),
        .in_valid (txq_valid),
        .in_ready (txq_pop),
        .txd      (txd)
    );

    // receive path
    uart_rx rx_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .rxd         (rxd),
        .byte_data   (rx_byte),
        .byte_strobe (rx_strobe),
        .frame_err   (frame_err)
    );

    // strobe ignores in_ready, so a full FIFO reports the drop
    uart_fifo rx_fifo_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_data   (rx_byte),
        .in_valid  (rx_strobe),
        .in_ready  (),
        .out_data  (rx_data),
        .out_valid (rx_valid),
        .out_ready (rx_ready),
        .overrun   (rx_overrun)
    );

endmodule

`default_nettype wire

//--- uart_rx.sv
// 8N1 deserializer with mid-bit sampling; no parity, no break detection, strobes have no back-pressure
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rxd,
    output logic [7:0] byte_data,
    output logic       byte_strobe,
    output logic       frame_err
);

    import uart_cfg_pkg::*;
    import uart_types_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    rx_state_t        state;
    logic             rxd_meta;
    logic             rxd_sync;
    logic             rxd_prev;
    logic             fall;
    logic [CNT_W-1:0] bit_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shreg;
    logic             half_end;
    logic             bit_end;

    // two-flop synchronizer, plus one more stage for edge detection
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    assign fall      = rxd_prev && !rxd_sync;
    assign half_end  = (bit_cnt == CNT_W'(HALF_BIT - 1));
    assign bit_end   = (bit_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign byte_data = shreg;

    // payload shifter, first bit ends up in bit 0
    always_ff @(posedge clk) begin
        if (state == RX_DATA && bit_end) begin
            shreg <= {rxd_sync, shreg[7:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= RX_IDLE;
            bit_cnt     <= '0;
            bit_idx     <= '0;
            byte_strobe <= 1'b0;
            frame_err   <= 1'b0;
        end else begin
            byte_strobe <= 1'b0;
            frame_err   <= 1'b0;
            case (state)
                RX_IDLE: begin
                    bit_cnt <= '0;
                    bit_idx <= '0;
                    if (fall) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (half_end) begin
                        bit_cnt <= '0;
                        // high at mid start bit means a glitch
                        state   <= rxd_sync ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_end) begin
                        bit_cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                RX_STOP: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_end) begin
                        state       <= RX_IDLE;
                        bit_cnt     <= '0;
                        byte_strobe <= rxd_sync;
                        frame_err   <= !rxd_sync;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- uart_tx.sv
// 8N1 serializer at uart_cfg_pkg::CLKS_PER_BIT clocks per bit; accepts a byte only when idle
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] in_data,
    input  logic       in_valid,
    output logic       in_ready,
    output logic       txd
);

    import uart_cfg_pkg::*;
    import uart_types_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    tx_state_t        state;
    logic [CNT_W-1:0] bit_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shreg;
    logic             txd_r;
    logic             bit_end;

    assign in_ready = (state == TX_IDLE);
    assign bit_end  = (bit_cnt == CNT_W'(CLKS_PER_BIT - 1));
    assign txd      = txd_r;

    // data shifter, LSB leaves first
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            shreg <= in_data;
        end else if (bit_end && (state == TX_START || state == TX_DATA)) begin
            shreg <= {1'b0, shreg[7:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= TX_IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
            txd_r   <= 1'b1;
        end else begin
            case (state)
                TX_IDLE: begin
                    bit_cnt <= '0;
                    bit_idx <= '0;
                    txd_r   <= 1'b1;
                    if (in_valid) begin
                        state <= TX_START;
                        txd_r <= 1'b0;
                    end
                end
                TX_START: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_end) begin
                        state   <= TX_DATA;
                        bit_cnt <= '0;
                        txd_r   <= shreg[0];
                    end
                end
                TX_DATA: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_end) begin
                        bit_cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            state <= TX_STOP;
                            txd_r <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            txd_r   <= shreg[0];
                        end
                    end
                end
                TX_STOP: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_end) begin
                        state   <= TX_IDLE;
                        bit_cnt <= '0;
                    end
                end
                default: begin
                    state <= TX_IDLE;
                    txd_r <= 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- uart_fifo.sv
// show-ahead byte FIFO, DEPTH >= 2; a push while full is dropped and flagged on overrun one cycle later
`timescale 1ns/1ps
`default_nettype none

module uart_fifo #(
    parameter int DEPTH = uart_cfg_pkg::FIFO_DEPTH
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] in_data,
    input  logic       in_valid,
    output logic       in_ready,
    output logic [7:0] out_data,
    output logic       out_valid,
    input  logic       out_ready,
    output logic       overrun
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [7:0]       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // wrap at DEPTH so non power of two depths work
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            overrun <= 1'b0;
        end else begin
            // push source may not wait, so a full FIFO loses the byte
            overrun <= in_valid && !in_ready;
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- uart_types_pkg.sv
// state encodings for the 8N1 transmitter and receiver; both fit in 2 bits
`default_nettype none

package uart_types_pkg;

    // transmitter sequence, one state per frame section
    typedef enum logic [1:0] {
        TX_IDLE  = 2'b00,
        TX_START = 2'b01,
        TX_DATA  = 2'b10,
        TX_STOP  = 2'b11
    } tx_state_t;

    // receiver sequence, RX_START covers the half-bit recheck
    typedef enum logic [1:0] {
        RX_IDLE  = 2'b00,
        RX_START = 2'b01,
        RX_DATA  = 2'b10,
        RX_STOP  = 2'b11
    } rx_state_t;

endpackage

`default_nettype wire

//--- uart_cfg_pkg.sv
// fixed clock and line rate; CLK_FREQ must be a whole multiple of BAUD_RATE, at least 2 clocks per bit
`default_nettype none

package uart_cfg_pkg;

    // system clock in Hz
    localparam int CLK_FREQ = 50_000_000;

    // line rate in baud, kept high so simulations stay short
    localparam int BAUD_RATE = 5_000_000;

    // bit time in clock cycles, no fractional division
    localparam int CLKS_PER_BIT = CLK_FREQ / BAUD_RATE;

    // offset from the start edge to the middle of the start bit
    localparam int HALF_BIT = CLKS_PER_BIT / 2;

    // default depth of the transmit and receive FIFOs
    localparam int FIFO_DEPTH = 4;

endpackage

`default_nettype wire
